// File: sim.f
hdl/mem_stage_pkg.sv
hdl/lsu_align.sv
hdl/lsu.sv
hdl/axi_lite_ram.sv
hdl/mem_stage_top.sv
bench/clock_gen.sv
bench/tb_mem_stage.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module tb_mem_stage \
	-o tb_mem_stage

./obj_dir/tb_mem_stage > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// File: bench/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage import mem_stage_pkg::*; ();

	localparam int mem_words = 256;
	localparam int max_stall = 3;
	localparam int n_direct  = 20;   // per instruction kind.
	localparam int n_stream  = 16;
	localparam int n_word    = 16;
	localparam int n_rounds  = 6;
	localparam int n_instr   = mem_words + 3 * n_direct + n_stream + 2 * n_word + 19 * n_rounds;
	localparam int watchdog_cycles = n_instr * (4 + 2 * max_stall + 4) + 100;

	logic        clock;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	exu_to_lsu_t in_bundle;
	logic        wb_valid;
	wb_t         wb;

	wb_t         exp_next;   // expectation for the bundle now driven.
	wb_t         exp_head;
	wb_t         exp_q [$];
	int          n_pend;
	logic [7:0]  shadow [mem_words * 4];
	string       test_name;
	int          errors = 0;
	int          err_mark;
	int          passed;
	int          failed;
	int          accepts;
	int          wbs;

	clock_gen #(.reset_cycles(4)) clock_i (.clock(clock), .rst_n(rst_n));

	mem_stage_top #(
		.mem_words (mem_words),
		.max_stall (max_stall)
	) dut_i (
		.clock, .rst_n, .in_valid, .in_ready, .in(in_bundle), .wb_valid, .wb
	);

	// ====================
	// reference model.
	function automatic word_t fill_word(input int idx);
		word_t a;
		a = word_t'(idx * 4);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic word_t load_expect(input word_t addr, input funct3_t f3);
		int a;
		a = int'(addr);
		case (f3)
			f3_lb:   return {{24{shadow[a][7]}}, shadow[a]};
			f3_lbu:  return {24'h000000, shadow[a]};
			f3_lh:   return {{16{shadow[a + 1][7]}}, shadow[a + 1], shadow[a]};
			f3_lhu:  return {16'h0000, shadow[a + 1], shadow[a]};
			f3_lw:   return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
			default: return '0;
		endcase
	endfunction

	function automatic void apply_store(input exu_to_lsu_t b);
		int a;
		a = int'(b.exu_val);
		for (int i = 0; i < 4; i++) begin
			if (b.wmask[i])
				shadow[a + i] = b.store_data[8*i +: 8];
		end
	endfunction

	function automatic wb_t expect_wb(input exu_to_lsu_t b);
		wb_t e;
		e.pc        = b.pc;
		e.reg_wen   = b.reg_wen;
		e.rd        = b.rd;
		e.csr_en    = b.csr_en;
		e.csr_addr  = b.csr_addr;
		e.csr_wdata = b.csr_wdata;
		e.ecall     = b.ecall;
		if (b.load_en)
			e.wb_val = load_expect(b.exu_val, b.funct3);
		else if (b.jal_en)
			e.wb_val = b.pc + 32'd4;   // jump wins over csr.
		else if (b.csr_en)
			e.wb_val = b.csr_val;
		else
			e.wb_val = b.exu_val;
		return e;
	endfunction

	function automatic wb_t strip_val(input wb_t x);
		wb_t y;
		y = x;
		y.wb_val = '0;
		return y;
	endfunction

	// ====================
	// bundles.
	function automatic exu_to_lsu_t base_bundle();
		exu_to_lsu_t b;
		b            = '0;
		b.rd         = reg_idx_t'($urandom);
		b.exu_val    = $urandom;
		b.csr_val    = $urandom;
		b.funct3     = funct3_t'($urandom);
		b.store_data = $urandom;
		b.wmask      = strb_t'($urandom);
		b.pc         = $urandom & 32'hffff_fffc;
		b.csr_wdata  = $urandom;
		b.csr_addr   = csr_addr_t'($urandom);
		b.reg_wen    = ($urandom % 2) == 1;
		b.ecall      = ($urandom % 2) == 1;
		return b;
	endfunction

	function automatic exu_to_lsu_t mem_bundle(input logic load, input funct3_t f3,
			input word_t addr, input word_t data, input strb_t mask);
		exu_to_lsu_t b;
		b            = base_bundle();
		b.exu_val    = addr;
		b.funct3     = f3;
		b.store_data = data;
		b.wmask      = mask;
		b.load_en    = load;
		b.store_en   = !load;
		return b;
	endfunction

	function automatic exu_to_lsu_t stream_item();
		exu_to_lsu_t b;
		b = base_bundle();
		if (($urandom % 2) == 1) begin
			b.load_en = 1'b1;
			b.funct3  = f3_lw;
			b.exu_val = word_t'($urandom_range(mem_words - 1) * 4);
		end
		return b;
	endfunction

	// ====================
	// driving.
	task automatic wait_wb();
		do @(negedge clock); while (!wb_valid);
	endtask

	task automatic send(input exu_to_lsu_t b);
		@(posedge clock);
		in_valid  <= 1'b1;
		in_bundle <= b;
		exp_next  <= expect_wb(b);
		if (b.store_en)
			apply_store(b);
		do @(negedge clock); while (!in_ready);
		@(posedge clock);   // accept edge.
		in_valid <= 1'b0;
		wait_wb();
	endtask

	// in_valid stays high while the stage is busy.
	task automatic stream(input int count);
		exu_to_lsu_t b;
		int sent;
		sent = 0;
		b = stream_item();
		@(posedge clock);
		in_valid  <= 1'b1;
		in_bundle <= b;
		exp_next  <= expect_wb(b);
		while (sent < count) begin
			@(negedge clock);
			if (in_ready) begin
				@(posedge clock);
				sent++;
				if (sent < count) begin
					b = stream_item();
					in_bundle <= b;
					exp_next  <= expect_wb(b);
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		wait_wb();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic end_test();
		repeat (3) @(posedge clock);   // writeback and release checks of the last one.
		@(negedge clock);
		if (errors == err_mark) begin
			passed++;
			$display("test %s: ok", test_name);
		end else begin
			failed++;
			$display("test %s: %0d error(s)", test_name, errors - err_mark);
		end
	endtask

	// ====================
	// expectation queue.
	always @(posedge clock) begin
		if (!rst_n) begin
			exp_q.delete();
			n_pend   <= 0;
			exp_head <= '0;
			accepts  = 0;
			wbs      = 0;
		end else begin
			if (in_valid && in_ready) begin
				exp_q.push_back(exp_next);
				accepts++;
			end
			if (wb_valid) begin
				if (exp_q.size() != 0)
					exp_q.delete(0);
				wbs++;
			end
			n_pend   <= exp_q.size();
			exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
		end
	end

	// ====================
	// checks.
	a_reset_idle: assert property (@(posedge clock) $rose(rst_n) |-> in_ready && !wb_valid)
		else begin
			errors++;
			$display("ERROR %s: after reset expected in_ready=1 wb_valid=0, actual %b %b",
				test_name, $sampled(in_ready), $sampled(wb_valid));
		end

	a_wb_pulse: assert property (@(posedge clock) disable iff (!rst_n) wb_valid |=> !wb_valid)
		else begin
			errors++;
			$display("%s: wb_valid stayed high for more than one cycle", test_name);
		end

	a_one_wb: assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> n_pend == 1)
		else begin
			errors++;
			$display("%s: writeback without exactly one accepted instruction", test_name);
		end

	a_no_accept_busy: assert property (@(posedge clock) disable iff (!rst_n)
		in_valid && in_ready |-> n_pend == 0)
		else begin
			errors++;
			$display("%s: instruction accepted while another was in flight", test_name);
		end

	a_release: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |=> !in_ready ##1 in_ready)
		else begin
			errors++;
			$display("%s: in_ready did not return on the edge after writeback", test_name);
		end

	a_direct_latency: assert property (@(posedge clock) disable iff (!rst_n)
		in_valid && in_ready && !in_bundle.load_en && !in_bundle.store_en |=> wb_valid)
		else begin
			errors++;
			$display("%s: no writeback one cycle after a non-memory instruction", test_name);
		end

	a_wb_value: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |-> wb.wb_val == exp_head.wb_val)
		else begin
			errors++;
			$display("ERROR %s: wb_val expected %h, actual %h",
				test_name, $sampled(exp_head.wb_val), $sampled(wb.wb_val));
		end

	a_wb_fields: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |-> strip_val(wb) == strip_val(exp_head))
		else begin
			errors++;
			$display("ERROR %s: wb fields expected %h, actual %h",
				test_name, strip_val($sampled(exp_head)), strip_val($sampled(wb)));
		end

	// ====================
	// stimulus.
	initial begin
		exu_to_lsu_t b;
		word_t a;
		void'($urandom(88));
		passed    = 0;
		failed    = 0;
		in_valid  = 1'b0;
		in_bundle = '0;
		exp_next  = '0;

		begin_test("reset");
		wait (rst_n === 1'b1);
		repeat (2) @(negedge clock);
		end_test();

		begin_test("direct");
		for (int i = 0; i < n_direct; i++) begin
			b = base_bundle();
			b.jal_en = 1'b1;
			b.csr_en = ($urandom % 2) == 1;
			send(b);
			b = base_bundle();
			b.csr_en = 1'b1;
			send(b);
			send(base_bundle());
		end
		end_test();

		begin_test("fill");
		for (int i = 0; i < mem_words; i++)
			send(mem_bundle(1'b0, f3_lw, word_t'(i * 4), fill_word(i), 4'b1111));
		end_test();

		begin_test("stream");
		stream(n_stream);
		end_test();

		begin_test("word");
		for (int i = 0; i < n_word; i++) begin
			a = word_t'($urandom_range(mem_words - 1) * 4);
			send(mem_bundle(1'b0, f3_lw, a, $urandom, 4'b1111));
			send(mem_bundle(1'b1, f3_lw, a, '0, '0));
		end
		end_test();

		begin_test("subword");
		for (int rnd = 0; rnd < n_rounds; rnd++) begin
			a = word_t'($urandom_range(mem_words - 1) * 4);
			for (int o = 0; o < 4; o++)
				send(mem_bundle(1'b0, f3_lb, a + word_t'(o), $urandom, 4'b0001));
			for (int o = 0; o < 4; o++) begin
				send(mem_bundle(1'b1, f3_lb, a + word_t'(o), '0, '0));
				send(mem_bundle(1'b1, f3_lbu, a + word_t'(o), '0, '0));
			end
			for (int o = 0; o < 4; o += 2)
				send(mem_bundle(1'b0, f3_lh, a + word_t'(o), $urandom, 4'b0011));
			for (int o = 0; o < 4; o += 2) begin
				send(mem_bundle(1'b1, f3_lh, a + word_t'(o), '0, '0));
				send(mem_bundle(1'b1, f3_lhu, a + word_t'(o), '0, '0));
			end
			send(mem_bundle(1'b1, f3_lw, a, '0, '0));   // merged word.
		end
		end_test();

		if (accepts != wbs)
			$display("accepted %0d instructions but saw %0d writebacks", accepts, wbs);
		$display("tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0 && accepts == wbs) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter int reset_cycles = 4
) (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;   // 10 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; #(
	parameter int mem_words = 256,
	parameter int max_stall = 3
) (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        in_valid,
	output logic        in_ready,
	input  exu_to_lsu_t in,
	output logic        wb_valid,
	output wb_t         wb
);

	axi_ar_t ar;
	logic    ar_valid;
	logic    ar_ready;
	axi_aw_t aw;
	logic    aw_valid;
	logic    aw_ready;
	axi_w_t  w;
	logic    w_valid;
	logic    w_ready;
	axi_r_t  r;
	logic    r_valid;
	logic    r_ready;
	axi_b_t  b;
	logic    b_valid;
	logic    b_ready;

	lsu lsu_i (
		.clock, .rst_n, .in_valid, .in_ready, .in, .wb_valid, .wb,
		.ar, .ar_valid, .ar_ready, .aw, .aw_valid, .aw_ready,
		.w, .w_valid, .w_ready, .r, .r_valid, .r_ready, .b, .b_valid, .b_ready
	);

	axi_lite_ram #(
		.mem_words (mem_words),
		.max_stall (max_stall)
	) ram_i (
		.clock, .rst_n,
		.ar, .ar_valid, .ar_ready, .aw, .aw_valid, .aw_ready,
		.w, .w_valid, .w_ready, .r, .r_valid, .r_ready, .b, .b_valid, .b_ready
	);

endmodule

// File: hdl/axi_lite_ram.sv
`timescale 1ns/1ps

module axi_lite_ram import mem_stage_pkg::*; #(
	parameter int mem_words = 256,
	parameter int max_stall = 3
) (
	input  logic    clock,
	input  logic    rst_n,
	input  axi_ar_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,
	input  axi_aw_t aw,
	input  logic    aw_valid,
	output logic    aw_ready,
	input  axi_w_t  w,
	input  logic    w_valid,
	output logic    w_ready,
	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready,
	output axi_b_t  b,
	output logic    b_valid,
	input  logic    b_ready
);

	localparam int idx_w = $clog2(mem_words);

	typedef logic [idx_w-1:0] idx_t;
	typedef logic [3:0]       cnt_t;

	word_t       mem [mem_words];
	logic [15:0] lfsr;
	cnt_t        ar_cnt;
	cnt_t        aw_cnt;
	cnt_t        w_cnt;
	cnt_t        r_cnt;
	cnt_t        b_cnt;
	logic        rd_pend;
	logic        wr_pend;
	logic        aw_done;
	logic        w_done;
	word_t       aw_addr_q;
	axi_w_t      w_q;
	word_t       r_data;
	logic        ar_hs;
	logic        aw_hs;
	logic        w_hs;
	logic        wr_fire;
	idx_t        wr_idx;
	axi_w_t      wr_beat;

	function automatic idx_t to_idx(input word_t a);
		return idx_t'((a >> 2) % mem_words);
	endfunction

	function automatic cnt_t pick(input logic [3:0] s);
		return cnt_t'(s % (max_stall + 1));   // 0 .. max_stall.
	endfunction

	assign ar_ready = ar_valid && ar_cnt == '0 && !rd_pend;
	assign aw_ready = aw_valid && aw_cnt == '0 && !aw_done && !wr_pend;
	assign w_ready  = w_valid && w_cnt == '0 && !w_done && !wr_pend;

	assign ar_hs = ar_valid && ar_ready;
	assign aw_hs = aw_valid && aw_ready;
	assign w_hs  = w_valid && w_ready;

	// write lands once both address and data are in.
	assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
	assign wr_idx  = to_idx(aw_hs ? aw.addr : aw_addr_q);
	assign wr_beat = w_hs ? w : w_q;

	assign r = '{data: r_data, resp: resp_okay};
	assign b = '{resp: resp_okay};

	// ====================
	// stalls and responses.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			lfsr    <= 16'hace1;
			ar_cnt  <= '0;
			aw_cnt  <= '0;
			w_cnt   <= '0;
			r_cnt   <= '0;
			b_cnt   <= '0;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
			r_valid <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

			if (ar_hs)
				ar_cnt <= pick(lfsr[3:0]);
			else if (ar_valid && ar_cnt != '0)
				ar_cnt <= ar_cnt - 1'b1;
			if (aw_hs)
				aw_cnt <= pick(lfsr[7:4]);
			else if (aw_valid && aw_cnt != '0)
				aw_cnt <= aw_cnt - 1'b1;
			if (w_hs)
				w_cnt <= pick(lfsr[11:8]);
			else if (w_valid && w_cnt != '0)
				w_cnt <= w_cnt - 1'b1;

			if (ar_hs) begin
				rd_pend <= 1'b1;
				r_cnt   <= pick(lfsr[15:12]);
			end else if (rd_pend && !r_valid) begin
				if (r_cnt == '0)
					r_valid <= 1'b1;
				else
					r_cnt <= r_cnt - 1'b1;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_pend <= 1'b0;
			end

			if (wr_fire) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
				wr_pend <= 1'b1;
				b_cnt   <= pick(lfsr[15:12]);
			end else begin
				if (aw_hs)
					aw_done <= 1'b1;
				if (w_hs)
					w_done <= 1'b1;
				if (wr_pend && !b_valid) begin
					if (b_cnt == '0)
						b_valid <= 1'b1;
					else
						b_cnt <= b_cnt - 1'b1;
				end
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				wr_pend <= 1'b0;
			end
		end
	end

	// ====================
	// array.
	always_ff @(posedge clock) begin
		if (aw_hs)
			aw_addr_q <= aw.addr;
		if (w_hs)
			w_q <= w;
		if (ar_hs)
			r_data <= mem[to_idx(ar.addr)];
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_beat.strb[i])
					mem[wr_idx][8*i +: 8] <= wr_beat.data[8*i +: 8];
			end
		end
	end

	a_b_after_write: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(b_valid) |-> $past(wr_pend) && !aw_done && !w_done);

	a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ps

module lsu import mem_stage_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        in_valid,
	output logic        in_ready,
	input  exu_to_lsu_t in,
	output logic        wb_valid,
	output wb_t         wb,
	output axi_ar_t     ar,
	output logic        ar_valid,
	input  logic        ar_ready,
	output axi_aw_t     aw,
	output logic        aw_valid,
	input  logic        aw_ready,
	output axi_w_t      w,
	output logic        w_valid,
	input  logic        w_ready,
	input  axi_r_t      r,
	input  logic        r_valid,
	output logic        r_ready,
	input  axi_b_t      b,
	input  logic        b_valid,
	output logic        b_ready
);

	lsu_state_e state;
	word_t      addr;
	funct3_t    funct3;
	word_t      store_data;
	strb_t      wmask;
	word_t      wdata;
	strb_t      wstrb;
	word_t      load_val;
	word_t      snpc;
	logic       accept;
	logic       ar_hs;
	logic       aw_hs;
	logic       w_hs;
	logic       r_hs;
	logic       b_hs;

	assign in_ready = (state == st_idle);
	assign wb_valid = (state == st_exec);   // one-cycle writeback.
	assign accept   = in_valid && in_ready;

	assign ar_hs = ar_valid && ar_ready;
	assign aw_hs = aw_valid && aw_ready;
	assign w_hs  = w_valid && w_ready;
	assign r_hs  = r_valid && r_ready;
	assign b_hs  = b_valid && b_ready;

	assign r_ready = 1'b1;
	assign b_ready = 1'b1;

	assign snpc = in.pc + 32'd4;

	// ====================
	// sequencing.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						if (in.load_en)
							state <= st_read;
						else if (in.store_en)
							state <= st_write;
						else
							state <= st_exec;
					end
				end
				st_read: begin
					if (r_hs)
						state <= st_exec;
				end
				st_write: begin
					if (b_hs)
						state <= st_exec;
				end
				st_exec: state <= st_done;
				st_done: state <= st_idle;   // upstream released next edge.
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ar_valid <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end else begin
			if (accept && in.load_en)
				ar_valid <= 1'b1;
			else if (ar_hs)
				ar_valid <= 1'b0;
			if (accept && in.store_en && !in.load_en)
				aw_valid <= 1'b1;
			else if (aw_hs)
				aw_valid <= 1'b0;
			if (accept && in.store_en && !in.load_en)
				w_valid <= 1'b1;
			else if (w_hs)
				w_valid <= 1'b0;
		end
	end

	// ====================
	// request and writeback payload.
	always_ff @(posedge clock) begin
		if (accept) begin
			addr       <= in.exu_val;
			funct3     <= in.funct3;
			store_data <= in.store_data;
			wmask      <= in.wmask;
			wb <= '{
				pc:        in.pc,
				wb_val:    in.jal_en ? snpc : (in.csr_en ? in.csr_val : in.exu_val),
				reg_wen:   in.reg_wen,
				rd:        in.rd,
				csr_en:    in.csr_en,
				csr_addr:  in.csr_addr,
				csr_wdata: in.csr_wdata,
				ecall:     in.ecall
			};
		end else if (r_hs) begin
			wb.wb_val <= load_val;
		end
	end

	lsu_align align_i (
		.addr_low   (addr[1:0]),
		.funct3     (funct3),
		.store_data (store_data),
		.wmask      (wmask),
		.rdata      (r.data),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.load_val   (load_val)
	);

	assign ar = '{addr: addr, size: axi_size_t'({1'b0, funct3[1:0]})};
	assign aw = '{addr: addr, size: axi_size_t'({1'b0, funct3[1:0]})};
	assign w  = '{data: wdata, strb: wstrb};

	// ====================
	// checks.
	a_one_request: assert property (@(posedge clock) disable iff (!rst_n)
		!(ar_valid && aw_valid));

	a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

	a_aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw));

	a_w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w));

	// upstream stays blocked through the release edge.
	a_wb_blocks: assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid |-> !in_ready ##1 !in_ready);

endmodule

// File: hdl/lsu_align.sv
`timescale 1ns/1ps

module lsu_align import mem_stage_pkg::*; (
	input  logic [1:0] addr_low,
	input  funct3_t    funct3,
	input  word_t      store_data,
	input  strb_t      wmask,
	input  word_t      rdata,
	output word_t      wdata,
	output strb_t      wstrb,
	output word_t      load_val
);

	logic [4:0]  bit_off;
	word_t       shifted;
	logic [7:0]  rd_byte;
	logic [15:0] rd_half;

	assign bit_off = {addr_low, 3'b000};

	// ====================
	// store lanes.
	assign wdata = store_data << bit_off;
	assign wstrb = wmask << addr_low;

	// ====================
	// load extraction.
	assign shifted = rdata >> bit_off;   // addressed byte to lane 0.
	assign rd_byte = shifted[7:0];
	assign rd_half = shifted[15:0];

	always_comb begin
		case (funct3)
			f3_lb: begin
				load_val = {{24{rd_byte[7]}}, rd_byte};
			end
			f3_lh: begin
				load_val = {{16{rd_half[15]}}, rd_half};
			end
			f3_lw: begin
				load_val = shifted;
			end
			f3_lbu: begin
				load_val = {24'h000000, rd_byte};
			end
			f3_lhu: begin
				load_val = {16'h0000, rd_half};
			end
			default: begin
				load_val = '0;   // not a load width.
			end
		endcase
	end

endmodule

// File: hdl/mem_stage_pkg.sv
package mem_stage_pkg;

	// ====================
	// widths.
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [3:0]  reg_idx_t;   // rv32e.
	typedef logic [11:0] csr_addr_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [2:0]  axi_size_t;
	typedef logic [1:0]  axi_resp_t;

	localparam funct3_t f3_lb  = 3'b000;
	localparam funct3_t f3_lh  = 3'b001;
	localparam funct3_t f3_lw  = 3'b010;
	localparam funct3_t f3_lbu = 3'b100;
	localparam funct3_t f3_lhu = 3'b101;

	localparam axi_resp_t resp_okay = 2'b00;

	// ====================
	// stage bundles.
	typedef struct packed {
		reg_idx_t  rd;
		word_t     exu_val;    // alu result, also the access address.
		word_t     csr_val;
		funct3_t   funct3;
		word_t     store_data;
		strb_t     wmask;
		logic      load_en;
		logic      store_en;
		word_t     pc;
		word_t     csr_wdata;
		csr_addr_t csr_addr;
		logic      csr_en;
		logic      jal_en;
		logic      reg_wen;
		logic      ecall;
	} exu_to_lsu_t;

	typedef struct packed {
		word_t     pc;
		word_t     wb_val;
		logic      reg_wen;
		reg_idx_t  rd;
		logic      csr_en;
		csr_addr_t csr_addr;
		word_t     csr_wdata;
		logic      ecall;
	} wb_t;

	// ====================
	// axi4-lite channels.
	typedef struct packed {
		word_t     addr;
		axi_size_t size;
	} axi_ar_t;

	typedef struct packed {
		word_t     addr;
		axi_size_t size;
	} axi_aw_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
	} axi_w_t;

	typedef struct packed {
		word_t     data;
		axi_resp_t resp;
	} axi_r_t;

	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

	typedef enum logic [2:0] {
		st_idle,
		st_exec,
		st_read,
		st_write,
		st_done
	} lsu_state_e;

endpackage
